//--- all.f
logic/noc_pkg.sv
logic/flit_fifo.sv
logic/flit_if_fifo.sv
logic/route_decoder.sv
logic/vc_arbiter.sv
logic/output_stage.sv
logic/input_unit.sv
verification/input_unit_tb.sv

//--- logic/flit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module flit_fifo (
  input  var logic           i_clk,
  input  var logic           i_rst,
  input  var logic           i_clear,
  input  var logic           i_push,
  input  var logic           i_pop,
  input  var noc_pkg::flit_t i_data,
  output var noc_pkg::flit_t o_data,
  output var logic           o_empty,
  output var logic           o_almost_full,
  output var logic           o_full
);

  noc_pkg::flit_t       mem [noc_pkg::DEPTH];
  noc_pkg::fifo_ptr_t   wr_ptr;
  noc_pkg::fifo_ptr_t   rd_ptr;
  noc_pkg::fifo_count_t count;
  noc_pkg::fifo_count_t count_next;
  logic                 empty_q;
  logic                 almost_full_q;
  logic                 full_q;
  logic                 push_en;
  logic                 pop_en;

  assign push_en = i_push & ~full_q;   // drop writes when full.
  assign pop_en  = i_pop & ~empty_q;

  always_comb begin
    count_next = count;
    case ({push_en, pop_en})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst || i_clear) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      empty_q       <= 1'b1;
      almost_full_q <= 1'b0;
      full_q        <= 1'b0;
    end else begin
      if (push_en) begin
        wr_ptr <= (wr_ptr == noc_pkg::fifo_ptr_t'(noc_pkg::DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_en) begin
        rd_ptr <= (rd_ptr == noc_pkg::fifo_ptr_t'(noc_pkg::DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count         <= count_next;
      // flags follow the next count so they line up with it.
      empty_q       <= (count_next == '0);
      almost_full_q <= (count_next >= noc_pkg::fifo_count_t'(noc_pkg::THRESHOLD));
      full_q        <= (count_next == noc_pkg::fifo_count_t'(noc_pkg::DEPTH));
    end
  end

  always_ff @(posedge i_clk) begin
    if (push_en) begin
      mem[wr_ptr] <= i_data;
    end
  end

  assign o_data        = mem[rd_ptr];   // head entry, no output register.
  assign o_empty       = empty_q;
  assign o_almost_full = almost_full_q;
  assign o_full        = full_q;

endmodule

`default_nettype wire

//--- logic/flit_if_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module flit_if_fifo (
  input  var logic                                     i_clk,
  input  var logic                                     i_rst,
  input  var logic                                     i_clear,
  input  var noc_pkg::vc_mask_t                        i_flit_valid,
  input  var noc_pkg::flit_t                           i_flit,
  output var noc_pkg::vc_mask_t                        o_flit_ready,
  output var noc_pkg::vc_mask_t                        o_vc_ready,
  input  var noc_pkg::vc_mask_t                        i_pop,
  output var noc_pkg::vc_mask_t                        o_empty,
  output var noc_pkg::flit_t [noc_pkg::CHANNELS-1:0]   o_head_flits
);

  noc_pkg::vc_mask_t almost_full;
  noc_pkg::vc_mask_t full;

  assign o_flit_ready = ~full;
  assign o_vc_ready   = ~almost_full;   // stop new packets early.

  // one buffer per virtual channel, all fed from the shared flit bus.
  for (genvar i = 0; i < noc_pkg::CHANNELS; i++) begin : g_vc
    flit_fifo u_fifo (
      .i_clk         (i_clk           ),
      .i_rst         (i_rst           ),
      .i_clear       (i_clear         ),
      .i_push        (i_flit_valid[i] ),
      .i_pop         (i_pop[i]        ),
      .i_data        (i_flit          ),
      .o_data        (o_head_flits[i] ),
      .o_empty       (o_empty[i]      ),
      .o_almost_full (almost_full[i]  ),
      .o_full        (full[i]         )
    );
  end

endmodule

`default_nettype wire

//--- logic/input_unit.sv
`timescale 1ns/1ps
`default_nettype none

module input_unit (
  input  var logic              i_clk,
  input  var logic              i_rst,
  input  var logic              i_clear,
  input  var noc_pkg::vc_mask_t i_flit_valid,
  input  var noc_pkg::flit_t    i_flit,
  output var noc_pkg::vc_mask_t o_flit_ready,
  output var noc_pkg::vc_mask_t o_vc_ready,
  input  var logic              i_out_ready,
  output var logic              o_out_valid,
  output var noc_pkg::flit_t    o_out_flit,
  output var noc_pkg::vc_id_t   o_out_vc,
  output var noc_pkg::port_t    o_out_port
);

  noc_pkg::vc_mask_t                      empty;
  noc_pkg::vc_mask_t                      pop;
  noc_pkg::flit_t [noc_pkg::CHANNELS-1:0] head_flits;
  logic                                   sel_valid;
  noc_pkg::flit_t                         sel_flit;
  noc_pkg::vc_id_t                        sel_vc;
  logic                                   take_head;
  noc_pkg::port_t                         sel_port;
  logic                                   load_ready;

  flit_if_fifo u_buffers (
    .i_clk        (i_clk        ),
    .i_rst        (i_rst        ),
    .i_clear      (i_clear      ),
    .i_flit_valid (i_flit_valid ),
    .i_flit       (i_flit       ),
    .o_flit_ready (o_flit_ready ),
    .o_vc_ready   (o_vc_ready   ),
    .i_pop        (pop          ),
    .o_empty      (empty        ),
    .o_head_flits (head_flits   )
  );

  vc_arbiter u_arbiter (
    .i_clk        (i_clk        ),
    .i_rst        (i_rst        ),
    .i_clear      (i_clear      ),
    .i_empty      (empty        ),
    .i_head_flits (head_flits   ),
    .i_load_ready (load_ready   ),
    .o_pop        (pop          ),
    .o_sel_valid  (sel_valid    ),
    .o_sel_flit   (sel_flit     ),
    .o_sel_vc     (sel_vc       ),
    .o_take_head  (take_head    )
  );

  route_decoder u_route (
    .i_clk        (i_clk        ),
    .i_rst        (i_rst        ),
    .i_clear      (i_clear      ),
    .i_flit       (sel_flit     ),
    .i_take_head  (take_head    ),
    .o_port       (sel_port     )
  );

  output_stage u_output (
    .i_clk        (i_clk        ),
    .i_rst        (i_rst        ),
    .i_clear      (i_clear      ),
    .i_valid      (sel_valid    ),
    .i_flit       (sel_flit     ),
    .i_vc         (sel_vc       ),
    .i_port       (sel_port     ),
    .o_load_ready (load_ready   ),
    .i_out_ready  (i_out_ready  ),
    .o_out_valid  (o_out_valid  ),
    .o_out_flit   (o_out_flit   ),
    .o_out_vc     (o_out_vc     ),
    .o_out_port   (o_out_port   )
  );

endmodule

`default_nettype wire

//--- logic/noc_pkg.sv
`default_nettype none

package noc_pkg;

  // ----------------------------------------------------------------------
  // sizes
  // ----------------------------------------------------------------------
  localparam int CHANNELS      = 4;
  localparam int DEPTH         = 8;
  localparam int THRESHOLD     = 6;
  localparam int TYPE_WIDTH    = 2;
  localparam int PAYLOAD_WIDTH = 16;
  localparam int FLIT_WIDTH    = TYPE_WIDTH + PAYLOAD_WIDTH;
  localparam int COORD_WIDTH   = 2;
  localparam int PORTS         = 5;
  localparam int PTR_WIDTH     = $clog2(DEPTH);
  localparam int COUNT_WIDTH   = $clog2(DEPTH + 1);

  // fixed mesh position of this router.
  localparam int ROUTER_X = 1;
  localparam int ROUTER_Y = 1;

  // destination fields inside a head flit payload.
  localparam int DEST_X_LSB = 2;
  localparam int DEST_Y_LSB = 0;

  // one-hot port bit positions.
  localparam int PORT_LOCAL = 0;
  localparam int PORT_EAST  = 1;
  localparam int PORT_WEST  = 2;
  localparam int PORT_NORTH = 3;
  localparam int PORT_SOUTH = 4;

  // ----------------------------------------------------------------------
  // types
  // ----------------------------------------------------------------------
  typedef logic [FLIT_WIDTH-1:0]  flit_t;
  typedef logic [CHANNELS-1:0]    vc_mask_t;
  typedef logic [1:0]             vc_id_t;
  typedef logic [COORD_WIDTH-1:0] coord_t;
  typedef logic [PORTS-1:0]       port_t;
  typedef logic [PTR_WIDTH-1:0]   fifo_ptr_t;
  typedef logic [COUNT_WIDTH-1:0] fifo_count_t;

  typedef enum logic [TYPE_WIDTH-1:0] {
    HEAD,
    BODY,
    TAIL,
    HEAD_TAIL     // single flit packet.
  } flit_type_e;

  typedef enum logic {
    IDLE,
    LOCKED
  } arb_state_e;

endpackage

`default_nettype wire

//--- logic/output_stage.sv
`timescale 1ns/1ps
`default_nettype none

module output_stage (
  input  var logic            i_clk,
  input  var logic            i_rst,
  input  var logic            i_clear,
  input  var logic            i_valid,
  input  var noc_pkg::flit_t  i_flit,
  input  var noc_pkg::vc_id_t i_vc,
  input  var noc_pkg::port_t  i_port,
  output var logic            o_load_ready,
  input  var logic            i_out_ready,
  output var logic            o_out_valid,
  output var noc_pkg::flit_t  o_out_flit,
  output var noc_pkg::vc_id_t o_out_vc,
  output var noc_pkg::port_t  o_out_port
);

  logic            valid_q;
  noc_pkg::flit_t  flit_q;
  noc_pkg::vc_id_t vc_q;
  noc_pkg::port_t  port_q;
  logic            load;

  assign o_load_ready = ~valid_q | i_out_ready;   // empty or draining.
  assign load         = i_valid & o_load_ready;

  always_ff @(posedge i_clk) begin
    if (i_rst || i_clear) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (i_out_ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (load) begin
      flit_q <= i_flit;
      vc_q   <= i_vc;
      port_q <= i_port;
    end
  end

  assign o_out_valid = valid_q;
  assign o_out_flit  = flit_q;
  assign o_out_vc    = vc_q;
  assign o_out_port  = port_q;

endmodule

`default_nettype wire

//--- logic/route_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module route_decoder (
  input  var logic           i_clk,
  input  var logic           i_rst,
  input  var logic           i_clear,
  input  var noc_pkg::flit_t i_flit,
  input  var logic           i_take_head,
  output var noc_pkg::port_t o_port
);

  noc_pkg::flit_type_e flit_type;
  noc_pkg::coord_t     dest_x;
  noc_pkg::coord_t     dest_y;
  noc_pkg::port_t      xy_port;
  noc_pkg::port_t      held_port;
  logic                is_head;

  assign flit_type = noc_pkg::flit_type_e'(i_flit[noc_pkg::FLIT_WIDTH-1 -: noc_pkg::TYPE_WIDTH]);
  assign dest_x    = i_flit[noc_pkg::DEST_X_LSB +: noc_pkg::COORD_WIDTH];
  assign dest_y    = i_flit[noc_pkg::DEST_Y_LSB +: noc_pkg::COORD_WIDTH];
  assign is_head   = (flit_type == noc_pkg::HEAD) || (flit_type == noc_pkg::HEAD_TAIL);

  // x first, then y.
  always_comb begin
    xy_port = '0;
    if (dest_x > noc_pkg::coord_t'(noc_pkg::ROUTER_X)) begin
      xy_port[noc_pkg::PORT_EAST] = 1'b1;
    end else if (dest_x < noc_pkg::coord_t'(noc_pkg::ROUTER_X)) begin
      xy_port[noc_pkg::PORT_WEST] = 1'b1;
    end else if (dest_y > noc_pkg::coord_t'(noc_pkg::ROUTER_Y)) begin
      xy_port[noc_pkg::PORT_NORTH] = 1'b1;
    end else if (dest_y < noc_pkg::coord_t'(noc_pkg::ROUTER_Y)) begin
      xy_port[noc_pkg::PORT_SOUTH] = 1'b1;
    end else begin
      xy_port[noc_pkg::PORT_LOCAL] = 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst || i_clear) begin
      held_port <= noc_pkg::port_t'(1) << noc_pkg::PORT_LOCAL;
    end else if (i_take_head) begin
      held_port <= xy_port;   // kept for body and tail.
    end
  end

  assign o_port = is_head ? xy_port : held_port;

endmodule

`default_nettype wire

//--- logic/vc_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module vc_arbiter (
  input  var logic                                   i_clk,
  input  var logic                                   i_rst,
  input  var logic                                   i_clear,
  input  var noc_pkg::vc_mask_t                      i_empty,
  input  var noc_pkg::flit_t [noc_pkg::CHANNELS-1:0] i_head_flits,
  input  var logic                                   i_load_ready,
  output var noc_pkg::vc_mask_t                      o_pop,
  output var logic                                   o_sel_valid,
  output var noc_pkg::flit_t                         o_sel_flit,
  output var noc_pkg::vc_id_t                        o_sel_vc,
  output var logic                                   o_take_head
);

  noc_pkg::arb_state_e state;
  noc_pkg::vc_id_t     locked_vc;
  noc_pkg::vc_id_t     rr_ptr;
  noc_pkg::vc_id_t     grant_vc;
  logic                grant_valid;
  logic                fire;
  noc_pkg::flit_type_e sel_type;

  // ----------------------------------------------------------------------
  // grant
  // ----------------------------------------------------------------------
  always_comb begin
    noc_pkg::vc_id_t idx;
    idx         = rr_ptr;
    grant_valid = 1'b0;
    grant_vc    = rr_ptr;
    if (state == noc_pkg::LOCKED) begin
      grant_valid = ~i_empty[locked_vc];
      grant_vc    = locked_vc;
    end else begin
      // walk backwards so the nearest channel to the pointer wins.
      for (int i = noc_pkg::CHANNELS - 1; i >= 0; i--) begin
        idx = noc_pkg::vc_id_t'((int'(rr_ptr) + i) % noc_pkg::CHANNELS);
        if (!i_empty[idx]) begin
          grant_valid = 1'b1;
          grant_vc    = idx;
        end
      end
    end
  end

  assign fire     = grant_valid & i_load_ready;
  assign sel_type = noc_pkg::flit_type_e'(o_sel_flit[noc_pkg::FLIT_WIDTH-1 -: noc_pkg::TYPE_WIDTH]);

  always_comb begin
    o_pop = '0;
    if (fire) begin
      o_pop[grant_vc] = 1'b1;
    end
  end

  assign o_sel_valid = grant_valid;
  assign o_sel_flit  = i_head_flits[grant_vc];
  assign o_sel_vc    = grant_vc;
  assign o_take_head = fire &&
                       ((sel_type == noc_pkg::HEAD) || (sel_type == noc_pkg::HEAD_TAIL));

  // ----------------------------------------------------------------------
  // packet lock
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst || i_clear) begin
      state     <= noc_pkg::IDLE;
      locked_vc <= '0;
      rr_ptr    <= '0;
    end else if (fire) begin
      case (sel_type)
        noc_pkg::HEAD: begin
          state     <= noc_pkg::LOCKED;
          locked_vc <= grant_vc;
        end
        noc_pkg::TAIL, noc_pkg::HEAD_TAIL: begin
          state  <= noc_pkg::IDLE;
          rr_ptr <= (grant_vc == noc_pkg::vc_id_t'(noc_pkg::CHANNELS - 1)) ?
                    '0 : grant_vc + 1'b1;   // skip the served channel.
        end
        default: state <= state;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build the input unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module input_unit_tb -f all.f -o sim_input_unit || exit 1

sim_out="$(./obj_dir/sim_input_unit 2>&1)"
echo "$sim_out"

echo "$sim_out" | grep -q "^Simulation PASSED$" && echo "result: pass" || { echo "result: fail"; exit 1; }

//--- verification/input_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module input_unit_tb;

  logic              i_clk;
  logic              i_rst;
  logic              i_clear;
  noc_pkg::vc_mask_t i_flit_valid;
  noc_pkg::flit_t    i_flit;
  noc_pkg::vc_mask_t o_flit_ready;
  noc_pkg::vc_mask_t o_vc_ready;
  logic              i_out_ready;
  logic              o_out_valid;
  noc_pkg::flit_t    o_out_flit;
  noc_pkg::vc_id_t   o_out_vc;
  noc_pkg::port_t    o_out_port;

  // packet table, one entry per packet.
  string row_name  [$];
  int    row_ch    [$];
  int    row_dx    [$];
  int    row_dy    [$];
  int    row_len   [$];
  int    row_first [$];

  // per-channel scoreboards.
  noc_pkg::flit_t exp_flit [noc_pkg::CHANNELS][$];
  noc_pkg::port_t exp_port [noc_pkg::CHANNELS][$];
  int             exp_row  [noc_pkg::CHANNELS][$];

  integer seed;
  int     cycles;
  int     cycle_limit;
  logic   stall_random;
  logic   lock_active;
  int     lock_vc;

  input_unit DUT (
    .i_clk        (i_clk        ),
    .i_rst        (i_rst        ),
    .i_clear      (i_clear      ),
    .i_flit_valid (i_flit_valid ),
    .i_flit       (i_flit       ),
    .o_flit_ready (o_flit_ready ),
    .o_vc_ready   (o_vc_ready   ),
    .i_out_ready  (i_out_ready  ),
    .o_out_valid  (o_out_valid  ),
    .o_out_flit   (o_out_flit   ),
    .o_out_vc     (o_out_vc     ),
    .o_out_port   (o_out_port   )
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic compare_values(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual));
    end
  endtask

  task automatic add_row(input string name, input int ch, input int dx, input int dy,
                         input int len, input int first);
    row_name.push_back(name);
    row_ch.push_back(ch);
    row_dx.push_back(dx);
    row_dy.push_back(dy);
    row_len.push_back(len);
    row_first.push_back(first);
  endtask

  // xy routing, x resolved before y.
  function automatic noc_pkg::port_t expected_port(input int dx, input int dy);
    noc_pkg::port_t port;
    port = '0;
    if (dx > noc_pkg::ROUTER_X) port[noc_pkg::PORT_EAST] = 1'b1;
    else if (dx < noc_pkg::ROUTER_X) port[noc_pkg::PORT_WEST] = 1'b1;
    else if (dy > noc_pkg::ROUTER_Y) port[noc_pkg::PORT_NORTH] = 1'b1;
    else if (dy < noc_pkg::ROUTER_Y) port[noc_pkg::PORT_SOUTH] = 1'b1;
    else port[noc_pkg::PORT_LOCAL] = 1'b1;
    return port;
  endfunction

  function automatic noc_pkg::flit_t make_flit(input int r, input int k);
    noc_pkg::flit_type_e ftype;
    logic [15:0]         payload;
    payload = 16'(row_first[r] + k);
    if (row_len[r] == 1) ftype = noc_pkg::HEAD_TAIL;
    else if (k == 0) ftype = noc_pkg::HEAD;
    else if (k == row_len[r] - 1) ftype = noc_pkg::TAIL;
    else ftype = noc_pkg::BODY;
    if (k == 0) payload = {payload[15:4], 2'(row_dx[r]), 2'(row_dy[r])};   // dest in head.
    return {ftype, payload};
  endfunction

  function automatic int pending_flits();
    int total;
    total = 0;
    for (int c = 0; c < noc_pkg::CHANNELS; c++) total += exp_flit[c].size();
    return total;
  endfunction

  task automatic flush_scoreboards();
    for (int c = 0; c < noc_pkg::CHANNELS; c++) begin
      exp_flit[c].delete();
      exp_port[c].delete();
      exp_row[c].delete();
    end
    lock_active = 1'b0;
  endtask

  // called at the rising edge, before the DUT registers update.
  task automatic observe_output();
    int             vc;
    int             r;
    noc_pkg::flit_t flit;
    noc_pkg::port_t port;
    if (o_out_valid && i_out_ready) begin
      vc = int'(o_out_vc);
      if (exp_flit[vc].size() == 0) begin
        abort_run($sformatf("flit 0x%0h left on channel %0d with none pending there",
                            o_out_flit, vc));
      end else begin
        flit = exp_flit[vc].pop_front();
        port = exp_port[vc].pop_front();
        r    = exp_row[vc].pop_front();
        if (lock_active) compare_values({row_name[r], "/contiguity"}, 32'(lock_vc), 32'(vc));
        compare_values({row_name[r], "/flit"}, 32'(flit), 32'(o_out_flit));
        compare_values({row_name[r], "/port"}, 32'(port), 32'(o_out_port));
        case (noc_pkg::flit_type_e'(o_out_flit[17:16]))
          noc_pkg::HEAD: begin
            lock_active = 1'b1;
            lock_vc     = vc;
          end
          noc_pkg::TAIL, noc_pkg::HEAD_TAIL: lock_active = 1'b0;
          default: ;
        endcase
      end
    end
  endtask

  // one clock, ends on the falling edge where inputs change.
  task automatic step();
    @(posedge i_clk);
    observe_output();
    cycles++;
    if (cycles > cycle_limit) begin
      abort_run($sformatf("timeout, run not finished after %0d clock cycles", cycle_limit));
    end
    @(negedge i_clk);
    if (stall_random) i_out_ready = ($random(seed) & 3) != 0;   // ready about 3 in 4.
  endtask

  task automatic send_flit(input int r, input int k);
    int             ch;
    noc_pkg::flit_t flit;
    ch = row_ch[r];
    while (!o_flit_ready[ch] || (k == 0 && !o_vc_ready[ch])) begin
      i_flit_valid = '0;   // a new packet also waits for vc_ready.
      step();
    end
    flit = make_flit(r, k);
    exp_flit[ch].push_back(flit);
    exp_port[ch].push_back(expected_port(row_dx[r], row_dy[r]));
    exp_row[ch].push_back(r);
    i_flit_valid = noc_pkg::vc_mask_t'(1 << ch);
    i_flit       = flit;
    step();
  endtask

  task automatic send_packet(input int r, input int count);
    for (int k = 0; k < count; k++) send_flit(r, k);
    i_flit_valid = '0;
  endtask

  task automatic drain();
    stall_random = 1'b1;
    while (pending_flits() != 0) step();
  endtask

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin
    int                total;
    noc_pkg::vc_mask_t all_ready;
    seed         = 5618;
    i_rst        = 1'b1;
    i_clear      = 1'b0;
    i_flit_valid = '0;
    i_flit       = '0;
    i_out_ready  = 1'b0;
    stall_random = 1'b0;
    lock_active  = 1'b0;
    lock_vc      = 0;
    cycles       = 0;
    all_ready    = '1;

    //      name             ch dx dy len                  first payload
    add_row("local_short",   0, 1, 1, 3,                   'h0100);
    add_row("east_single",   1, 2, 1, 1,                   'h0210);
    add_row("west_long",     2, 0, 2, 5,                   'h0320);
    add_row("north_pkt",     3, 1, 3, 4,                   'h0430);
    add_row("south_pkt",     0, 1, 0, 2,                   'h0540);
    add_row("east_far",      1, 3, 0, 3,                   'h0650);
    add_row("west_single",   2, 0, 0, 1,                   'h0760);
    add_row("north_near",    3, 1, 2, 6,                   'h0870);
    add_row("fill_flags",    2, 2, 3, noc_pkg::DEPTH + 1,  'h0980);
    add_row("clear_part_a",  0, 0, 1, noc_pkg::DEPTH + 2,  'h0a90);
    add_row("clear_part_b",  1, 1, 3, 3,                   'h0ba0);
    add_row("after_clear_a", 0, 3, 3, 3,                   'h0cb0);
    add_row("after_clear_b", 1, 1, 0, 2,                   'h0dc0);

    total = 0;
    foreach (row_len[r]) total += row_len[r];
    cycle_limit = 40 * total + 200;

    repeat (10) step();
    i_rst = 1'b0;
    compare_values("reset_state/out_valid", 0, 32'(o_out_valid));
    compare_values("reset_state/flit_ready", 32'(all_ready), 32'(o_flit_ready));
    compare_values("reset_state/vc_ready", 32'(all_ready), 32'(o_vc_ready));

    stall_random = 1'b1;
    for (int r = 0; r < 8; r++) send_packet(r, row_len[r]);
    drain();

    // output held off, the output stage keeps one flit and the FIFO the rest.
    stall_random = 1'b0;
    i_out_ready  = 1'b0;
    for (int k = 0; k < row_len[8]; k++) begin
      send_flit(8, k);
      compare_values("fill_flags/vc_ready", 32'(k < noc_pkg::THRESHOLD),
                     32'(o_vc_ready[row_ch[8]]));
      compare_values("fill_flags/flit_ready", 32'(k < noc_pkg::DEPTH),
                     32'(o_flit_ready[row_ch[8]]));
    end
    i_flit_valid = '0;
    drain();

    // channel 0 is left full and past the threshold before the clear.
    stall_random = 1'b0;
    i_out_ready  = 1'b0;
    send_packet(9, noc_pkg::DEPTH + 1);
    send_packet(10, 1);
    i_clear = 1'b1;
    step();
    i_clear = 1'b0;
    compare_values("clear/out_valid", 0, 32'(o_out_valid));
    compare_values("clear/flit_ready", 32'(all_ready), 32'(o_flit_ready));
    compare_values("clear/vc_ready", 32'(all_ready), 32'(o_vc_ready));
    flush_scoreboards();

    stall_random = 1'b1;
    send_packet(11, row_len[11]);
    send_packet(12, row_len[12]);
    drain();
    compare_values("end_state/out_valid", 0, 32'(o_out_valid));

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire
